/* rtl/board_pkg.sv */
/*
 * Board pad ring definitions: pad widths, UART pin mapping,
 * LED mapping and the peripheral reset sequencer states
 */
`default_nettype none

package board_pkg;

  // ====================================================================
  // Pad widths
  // ====================================================================
  localparam int GPIO_WIDTH = 32;
  localparam int QSPI_WIDTH = 4;
  localparam int LED_WIDTH  = 8;

  typedef logic [GPIO_WIDTH-1:0] gpio_word_t;
  typedef logic [QSPI_WIDTH-1:0] qspi_dq_t;
  typedef logic [LED_WIDTH-1:0]  led_t;

  // ====================================================================
  // Pin mapping
  // ====================================================================
  // UART receive pin feeds this GPIO input
  localparam int UART_RX_BIT = 16;
  // UART transmit pin follows this GPIO output
  localparam int UART_TX_BIT = 17;

  // Low GPIO bits shown on the LEDs
  localparam int LED_GPIO_COUNT = 4;
  // Power indicator
  localparam int LED_ALWAYS_ON  = 7;

  // Peripheral reset sequencer
  typedef enum logic [1:0] {
    RST_HOLD = 2'd0,
    RST_WAIT = 2'd1,
    RST_RUN  = 2'd2
  } rst_state_t;

endpackage

`default_nettype wire

/* rtl/slow_tick_gen.sv */
/*
 * Always-on slow tick: one-cycle enable strobe every DIV_RATIO core cycles
 */
`timescale 1ns/1ps
`default_nettype none

module slow_tick_gen #(
  parameter int DIV_RATIO = 256
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic pll_locked_i,
  output logic lf_tick_o
);

  localparam int CNT_W = (DIV_RATIO > 1) ? $clog2(DIV_RATIO) : 1;

  logic [CNT_W-1:0] cnt_q;
  logic             wrap;

  assign wrap = (cnt_q == CNT_W'(DIV_RATIO - 1));

  // Counter runs only once the PLL has locked
  always_ff @(posedge clk_i) begin
    if (rst_i || !pll_locked_i) begin
      cnt_q     <= '0;
      lf_tick_o <= 1'b0;
    end else begin
      lf_tick_o <= wrap;
      if (wrap) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Strobe is a single cycle wide
  a_tick_single : assert property (
    @(posedge clk_i) disable iff (rst_i)
    lf_tick_o |=> !lf_tick_o
  );

endmodule

`default_nettype wire

/* rtl/reset_sequencer.sv */
/*
 * Peripheral reset sequencer: holds reset on key press or PLL unlock,
 * releases it HOLD_TICKS slow ticks after both clear
 */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
  parameter int HOLD_TICKS = 4
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic ext_rst_n_i,
  input  logic pll_locked_i,
  input  logic lf_tick_i,
  output logic periph_rst_o
);

  localparam int TICK_W = $clog2(HOLD_TICKS + 1);

  logic [1:0]          key_sync_q;
  logic [1:0]          lock_sync_q;
  logic                key_ok;
  logic                lock_ok;
  logic                fault;
  logic [TICK_W-1:0]   tick_cnt_q;
  logic                last_tick;

  board_pkg::rst_state_t state_q;
  board_pkg::rst_state_t state_d;

  // ====================================================================
  // Input synchronisers
  // ====================================================================
  // Cleared to the fault level so reset stays asserted
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      key_sync_q  <= '0;
      lock_sync_q <= '0;
    end else begin
      key_sync_q  <= {key_sync_q[0], ext_rst_n_i};
      lock_sync_q <= {lock_sync_q[0], pll_locked_i};
    end
  end

  assign key_ok  = key_sync_q[1];
  assign lock_ok = lock_sync_q[1];
  assign fault   = !key_ok || !lock_ok;

  // ====================================================================
  // Release FSM
  // ====================================================================
  assign last_tick = lf_tick_i && (tick_cnt_q == TICK_W'(HOLD_TICKS - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      board_pkg::RST_HOLD: begin
        if (!fault) begin
          state_d = board_pkg::RST_WAIT;
        end
      end
      board_pkg::RST_WAIT: begin
        if (fault) begin
          state_d = board_pkg::RST_HOLD;
        end else if (last_tick) begin
          state_d = board_pkg::RST_RUN;
        end
      end
      board_pkg::RST_RUN: begin
        if (fault) begin
          state_d = board_pkg::RST_HOLD;
        end
      end
      default: state_d = board_pkg::RST_HOLD;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= board_pkg::RST_HOLD;
    end else begin
      state_q <= state_d;
    end
  end

  // Slow ticks seen while waiting
  always_ff @(posedge clk_i) begin
    if (rst_i || state_q != board_pkg::RST_WAIT) begin
      tick_cnt_q <= '0;
    end else if (lf_tick_i) begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
    end
  end

  assign periph_rst_o = (state_q != board_pkg::RST_RUN);

  // Losing lock always drops back out of run
  a_no_run_unlocked : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !lock_ok |=> (state_q != board_pkg::RST_RUN)
  );

endmodule

`default_nettype wire

/* rtl/gpio_pad_bank.sv */
/*
 * GPIO pad bank: output and input gating, UART pin routing, LEDs
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_pad_bank (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  board_pkg::gpio_word_t soc_gpio_oval_i,
  input  board_pkg::gpio_word_t soc_gpio_oe_i,
  input  board_pkg::gpio_word_t soc_gpio_ie_i,
  input  board_pkg::gpio_word_t gpio_pad_i,
  input  logic                 uart_rx_i,
  output board_pkg::gpio_word_t soc_gpio_ival_o,
  output board_pkg::gpio_word_t gpio_pad_o,
  output board_pkg::gpio_word_t gpio_pad_oe_o,
  output logic                 uart_tx_o,
  output board_pkg::led_t      led_o
);

  board_pkg::gpio_word_t pad_word;
  board_pkg::gpio_word_t sync1_q;
  board_pkg::gpio_word_t sync2_q;
  board_pkg::gpio_word_t driven;

  // ====================================================================
  // Output side
  // ====================================================================
  assign gpio_pad_o    = soc_gpio_oval_i;
  assign gpio_pad_oe_o = soc_gpio_oe_i;

  // Value actually driven onto each pad
  assign driven    = soc_gpio_oval_i & soc_gpio_oe_i;
  assign uart_tx_o = driven[board_pkg::UART_TX_BIT];

  always_comb begin
    led_o = '0;
    led_o[board_pkg::LED_GPIO_COUNT-1:0] = driven[board_pkg::LED_GPIO_COUNT-1:0];
    led_o[board_pkg::LED_ALWAYS_ON] = 1'b1;
  end

  // ====================================================================
  // Input side
  // ====================================================================
  // UART receive replaces the shared pad
  always_comb begin
    pad_word = gpio_pad_i;
    pad_word[board_pkg::UART_RX_BIT] = uart_rx_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= pad_word;
      sync2_q <= sync1_q;
    end
  end

  // Enables gate the synchronised value directly
  assign soc_gpio_ival_o = sync2_q & soc_gpio_ie_i;

  a_tx_needs_oe : assert property (
    @(posedge clk_i) disable iff (rst_i)
    uart_tx_o |-> soc_gpio_oe_i[board_pkg::UART_TX_BIT]
  );

endmodule

`default_nettype wire

/* rtl/riscv_board_pads.sv */
/*
 * RISC-V board pad ring: slow tick, reset sequencing, GPIO bank,
 * QSPI and JTAG pads
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_board_pads #(
  parameter int DIV_RATIO  = 256,
  parameter int HOLD_TICKS = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  ext_rst_n_i,
  input  logic                  pll_locked_i,
  output logic                  lf_tick_o,
  output logic                  aon_erst_n_o,

  // GPIO
  input  board_pkg::gpio_word_t soc_gpio_oval_i,
  input  board_pkg::gpio_word_t soc_gpio_oe_i,
  input  board_pkg::gpio_word_t soc_gpio_ie_i,
  input  board_pkg::gpio_word_t gpio_pad_i,
  input  logic                  uart_rx_i,
  output board_pkg::gpio_word_t soc_gpio_ival_o,
  output board_pkg::gpio_word_t gpio_pad_o,
  output board_pkg::gpio_word_t gpio_pad_oe_o,
  output logic                  uart_tx_o,
  output board_pkg::led_t       led_o,

  // QSPI
  input  logic                  soc_qspi_sck_i,
  input  logic                  soc_qspi_cs_i,
  input  board_pkg::qspi_dq_t   soc_qspi_dq_oval_i,
  input  board_pkg::qspi_dq_t   soc_qspi_dq_oe_i,
  input  board_pkg::qspi_dq_t   qspi_dq_i,
  output logic                  qspi_sck_o,
  output logic                  qspi_cs_o,
  output board_pkg::qspi_dq_t   qspi_dq_o,
  output board_pkg::qspi_dq_t   qspi_dq_oe_o,
  output board_pkg::qspi_dq_t   soc_qspi_dq_o,

  // JTAG
  input  logic                  jtag_tck_i,
  input  logic                  jtag_tms_i,
  input  logic                  jtag_tdi_i,
  input  logic                  soc_jtag_tdo_i,
  input  logic                  soc_jtag_tdo_oe_i,
  output logic                  soc_jtag_tck_o,
  output logic                  soc_jtag_tms_o,
  output logic                  soc_jtag_tdi_o,
  output logic                  jtag_tdo_o,
  output logic                  jtag_tdo_oe_o
);

  logic lf_tick;
  logic periph_rst;

  // ====================================================================
  // Clock enable and reset
  // ====================================================================
  slow_tick_gen #(
    .DIV_RATIO(DIV_RATIO)
  ) u_slow_tick (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .pll_locked_i(pll_locked_i),
    .lf_tick_o   (lf_tick)
  );

  reset_sequencer #(
    .HOLD_TICKS(HOLD_TICKS)
  ) u_rst_seq (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ext_rst_n_i (ext_rst_n_i),
    .pll_locked_i(pll_locked_i),
    .lf_tick_i   (lf_tick),
    .periph_rst_o(periph_rst)
  );

  assign lf_tick_o    = lf_tick;
  // SoC always-on reset is active low
  assign aon_erst_n_o = ~periph_rst;

  // ====================================================================
  // GPIO
  // ====================================================================
  gpio_pad_bank u_gpio (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .soc_gpio_oval_i(soc_gpio_oval_i),
    .soc_gpio_oe_i  (soc_gpio_oe_i),
    .soc_gpio_ie_i  (soc_gpio_ie_i),
    .gpio_pad_i     (gpio_pad_i),
    .uart_rx_i      (uart_rx_i),
    .soc_gpio_ival_o(soc_gpio_ival_o),
    .gpio_pad_o     (gpio_pad_o),
    .gpio_pad_oe_o  (gpio_pad_oe_o),
    .uart_tx_o      (uart_tx_o),
    .led_o          (led_o)
  );

  // ====================================================================
  // QSPI and JTAG pads
  // ====================================================================
  assign qspi_sck_o    = soc_qspi_sck_i;
  assign qspi_cs_o     = soc_qspi_cs_i;
  assign qspi_dq_o     = soc_qspi_dq_oval_i;
  assign qspi_dq_oe_o  = soc_qspi_dq_oe_i;
  assign soc_qspi_dq_o = qspi_dq_i;

  assign soc_jtag_tck_o = jtag_tck_i;
  assign soc_jtag_tms_o = jtag_tms_i;
  assign soc_jtag_tdi_o = jtag_tdi_i;
  // TDO tristate split into value and enable
  assign jtag_tdo_o     = soc_jtag_tdo_i;
  assign jtag_tdo_oe_o  = soc_jtag_tdo_oe_i;

endmodule

`default_nettype wire

/* verification/tb_riscv_board_pads.sv */
/*
 * Testbench for the board pad ring: slow tick, reset release, GPIO bank
 * and QSPI/JTAG pass-through
 */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_board_pads;

  localparam int DIV_RATIO  = 8;
  localparam int HOLD_TICKS = 4;
  // Full sequence needs roughly 700 cycles
  localparam int CYCLE_LIMIT = 3000;
  localparam int REL_MIN = (HOLD_TICKS - 1) * DIV_RATIO + 3;
  localparam int REL_MAX = HOLD_TICKS * DIV_RATIO + 4;

  logic clk_i;
  logic rst_i;
  logic ext_rst_n_i, pll_locked_i, lf_tick_o, aon_erst_n_o;
  board_pkg::gpio_word_t soc_gpio_oval_i, soc_gpio_oe_i, soc_gpio_ie_i, gpio_pad_i;
  board_pkg::gpio_word_t soc_gpio_ival_o, gpio_pad_o, gpio_pad_oe_o;
  logic uart_rx_i, uart_tx_o;
  board_pkg::led_t led_o;
  logic soc_qspi_sck_i, soc_qspi_cs_i, qspi_sck_o, qspi_cs_o;
  board_pkg::qspi_dq_t soc_qspi_dq_oval_i, soc_qspi_dq_oe_i, qspi_dq_i;
  board_pkg::qspi_dq_t qspi_dq_o, qspi_dq_oe_o, soc_qspi_dq_o;
  logic jtag_tck_i, jtag_tms_i, jtag_tdi_i, soc_jtag_tdo_i, soc_jtag_tdo_oe_i;
  logic soc_jtag_tck_o, soc_jtag_tms_o, soc_jtag_tdi_o, jtag_tdo_o, jtag_tdo_oe_o;

  logic [31:0] rng;
  int cycle_cnt = 0;
  int hist_valid = 0;
  // Pad history for the two-flop input path
  board_pkg::gpio_word_t pad_d1, pad_d2;
  logic rx_d1, rx_d2;

  riscv_board_pads #(
    .DIV_RATIO (DIV_RATIO),
    .HOLD_TICKS(HOLD_TICKS)
  ) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ====================================================================
  // Reference model and compare tasks
  // ====================================================================
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic void model_gpio(
    input  board_pkg::gpio_word_t oval, oe, ie, pad,
    input  logic rx,
    output board_pkg::gpio_word_t ival,
    output logic tx,
    output board_pkg::led_t led
  );
    board_pkg::gpio_word_t word;
    word = pad;
    word[board_pkg::UART_RX_BIT] = rx;
    ival = word & ie;
    tx = oval[board_pkg::UART_TX_BIT] & oe[board_pkg::UART_TX_BIT];
    led = '0;
    for (int i = 0; i < board_pkg::LED_GPIO_COUNT; i++) begin
      led[i] = oval[i] & oe[i];
    end
    led[board_pkg::LED_ALWAYS_ON] = 1'b1;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input board_pkg::gpio_word_t got, exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_led(input string name, input board_pkg::led_t got, exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_dq(input string name, input board_pkg::qspi_dq_t got, exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout: test still running after %0d cycles", cycle_cnt));
    end
  end

  // GPIO compare on every falling edge out of reset
  always @(negedge clk_i) begin : gpio_compare
    board_pkg::gpio_word_t exp_ival;
    logic exp_tx;
    board_pkg::led_t exp_led;
    if (rst_i) begin
      hist_valid = 0;
    end else begin
      model_gpio(soc_gpio_oval_i, soc_gpio_oe_i, soc_gpio_ie_i, pad_d2, rx_d2,
                 exp_ival, exp_tx, exp_led);
      check_word("gpio_pad_o", gpio_pad_o, soc_gpio_oval_i);
      check_word("gpio_pad_oe_o", gpio_pad_oe_o, soc_gpio_oe_i);
      check_bit("uart_tx_o", uart_tx_o, exp_tx);
      check_led("led_o", led_o, exp_led);
      if (hist_valid == 2) begin
        check_word("soc_gpio_ival_o", soc_gpio_ival_o, exp_ival);
      end else begin
        hist_valid++;
      end
      pad_d2 = pad_d1;
      rx_d2  = rx_d1;
      pad_d1 = gpio_pad_i;
      rx_d1  = uart_rx_i;
    end
  end

  // ====================================================================
  // Timing helpers
  // ====================================================================
  task automatic count_to_tick(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      @(negedge clk_i);
    end while (!lf_tick_o && cycles < 2 * DIV_RATIO);
  endtask

  task automatic wait_release(input string cause);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      @(negedge clk_i);
    end while (!aon_erst_n_o && cycles <= REL_MAX);
    if (!aon_erst_n_o) begin
      abort_run($sformatf("Reset still held %0d cycles after %s", cycles, cause));
    end else if (cycles < REL_MIN) begin
      abort_run($sformatf("Reset released after only %0d cycles after %s", cycles, cause));
    end
  endtask

  // Reset output must drop on the third edge and stay low
  task automatic check_reset_assert();
    for (int i = 1; i <= 4; i++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_bit("aon_erst_n_o", aon_erst_n_o, logic'(i < 3));
    end
  endtask

  // ====================================================================
  // Stimulus
  // ====================================================================
  initial begin
    int n;
    rng = 32'h78cc_e678;
    rst_i <= 1'b1;
    ext_rst_n_i <= 1'b0;
    pll_locked_i <= 1'b0;
    soc_gpio_oval_i <= '0;
    soc_gpio_oe_i <= '0;
    soc_gpio_ie_i <= '1;
    gpio_pad_i <= '0;
    uart_rx_i <= 1'b1;
    soc_qspi_sck_i <= 1'b0;
    soc_qspi_cs_i <= 1'b1;
    soc_qspi_dq_oval_i <= '0;
    soc_qspi_dq_oe_i <= '0;
    qspi_dq_i <= '0;
    jtag_tck_i <= 1'b0;
    jtag_tms_i <= 1'b0;
    jtag_tdi_i <= 1'b0;
    soc_jtag_tdo_i <= 1'b0;
    soc_jtag_tdo_oe_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_word("soc_gpio_ival_o", soc_gpio_ival_o, '0);
    check_bit("lf_tick_o", lf_tick_o, 1'b0);
    check_bit("aon_erst_n_o", aon_erst_n_o, 1'b0);

    // Divider held while unlocked
    repeat (30) begin
      @(negedge clk_i);
      check_bit("lf_tick_o", lf_tick_o, 1'b0);
    end
    @(posedge clk_i);
    pll_locked_i <= 1'b1;
    for (int k = 0; k < 5; k++) begin
      count_to_tick(n);
      if (n != DIV_RATIO) begin
        abort_run($sformatf("Tick came after %0d cycles, expected %0d", n, DIV_RATIO));
      end
    end

    // Reset release and re-assertion
    @(posedge clk_i);
    ext_rst_n_i <= 1'b1;
    wait_release("key release");
    @(posedge clk_i);
    ext_rst_n_i <= 1'b0;
    check_reset_assert();
    @(posedge clk_i);
    ext_rst_n_i <= 1'b1;
    wait_release("key release");
    @(posedge clk_i);
    pll_locked_i <= 1'b0;
    check_reset_assert();
    @(posedge clk_i);
    pll_locked_i <= 1'b1;
    wait_release("lock return");

    // GPIO outputs, then inputs
    repeat (200) begin
      @(posedge clk_i);
      rng = lcg_next(rng);
      soc_gpio_oval_i <= rng;
      rng = lcg_next(rng);
      soc_gpio_oe_i <= rng;
    end
    repeat (200) begin
      @(posedge clk_i);
      rng = lcg_next(rng);
      gpio_pad_i <= rng;
      uart_rx_i <= rng[7];
      rng = lcg_next(rng);
      soc_gpio_ie_i <= rng;
    end

    // QSPI and JTAG pass-through
    repeat (40) begin
      @(posedge clk_i);
      rng = lcg_next(rng);
      soc_qspi_sck_i <= rng[31];
      soc_qspi_cs_i <= rng[30];
      soc_qspi_dq_oval_i <= rng[27:24];
      soc_qspi_dq_oe_i <= rng[23:20];
      qspi_dq_i <= rng[19:16];
      jtag_tck_i <= rng[15];
      jtag_tms_i <= rng[14];
      jtag_tdi_i <= rng[13];
      soc_jtag_tdo_i <= rng[12];
      soc_jtag_tdo_oe_i <= rng[11];
      @(negedge clk_i);
      check_bit("qspi_sck_o", qspi_sck_o, rng[31]);
      check_bit("qspi_cs_o", qspi_cs_o, rng[30]);
      check_dq("qspi_dq_o", qspi_dq_o, rng[27:24]);
      check_dq("qspi_dq_oe_o", qspi_dq_oe_o, rng[23:20]);
      check_dq("soc_qspi_dq_o", soc_qspi_dq_o, rng[19:16]);
      check_bit("soc_jtag_tck_o", soc_jtag_tck_o, rng[15]);
      check_bit("soc_jtag_tms_o", soc_jtag_tms_o, rng[14]);
      check_bit("soc_jtag_tdi_o", soc_jtag_tdi_o, rng[13]);
      check_bit("jtag_tdo_o", jtag_tdo_o, rng[12]);
      check_bit("jtag_tdo_oe_o", jtag_tdo_oe_o, rng[11]);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
rtl/board_pkg.sv
rtl/slow_tick_gen.sv
rtl/reset_sequencer.sv
rtl/gpio_pad_bank.sv
rtl/riscv_board_pads.sv
verification/tb_riscv_board_pads.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_riscv_board_pads
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
